/* src/mapper_pkg.sv */
// Discrete mapper shared definitions
// Bus widths, flag fields and board family decode

package mapper_pkg;

	localparam int CART_ADDR_W = 22; // Mapped PRG/CHR address into cart memory
	localparam int CPU_ADDR_W  = 16; // CPU bus address
	localparam int PPU_ADDR_W  = 14; // PPU bus address
	localparam int DATA_W      = 8;  // CPU data bus
	localparam int FLAGS_W     = 32; // Cart flags word
	localparam int MAPPER_W    = 8;  // Mapper number field, flags[7:0]

	localparam int FLAG_MIRROR_VERT  = 14; // Set for vertical mirroring
	localparam int FLAG_CHR_RAM      = 15; // CHR is RAM, writes allowed
	localparam int FLAG_SUBMAPPER_LO = 21; // Low of the two submapper bits

	localparam logic [1:0] CHR_REGION = 2'b10; // CHR lives in upper half of cart memory

	// Supported board families
	typedef enum logic [2:0] {
		NROM         = 3'd0, // 0, no banking
		GXROM        = 3'd1, // 66
		CAMERICA     = 3'd2, // 71
		CAMERICA_232 = 3'd3, // 232, adds outer bank
		HOLY_DIVER   = 3'd4, // 78
		BANDAI_70    = 3'd5, // 70
		BANDAI_152   = 3'd6  // 152, one-screen
	} mapper_e;

	// Mapper number to family; anything unknown behaves as NROM
	function automatic mapper_e decode_mapper(input logic [MAPPER_W-1:0] num);
		case (num)
			8'd66:   return GXROM;
			8'd71:   return CAMERICA;
			8'd232:  return CAMERICA_232;
			8'd78:   return HOLY_DIVER;
			8'd70:   return BANDAI_70;
			8'd152:  return BANDAI_152;
			default: return NROM;
		endcase
	endfunction

endpackage

/* src/prg_bank_unit.sv */
// PRG bank registers and address map

`timescale 1ns/1ns

module prg_bank_unit import mapper_pkg::*; #(
	parameter int PRG_BANK_W = 4 // PRG bank register width
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,        // M2 strobe
	input  logic                   enable,    // Mapper enabled
	input  logic [FLAGS_W-1:0]     flags,     // Cart flags
	input  logic [CPU_ADDR_W-1:0]  prg_ain,   // CPU address
	input  logic                   prg_write, // CPU write level
	input  logic [DATA_W-1:0]      prg_din,   // CPU write data
	output logic [CART_ADDR_W-1:0] prg_map    // Mapped PRG address
);

	// 16K page number above the 14 bit offset
	localparam int PAGE_W = CART_ADDR_W - 14;
	// Fixed $C000 bank for the 16K boards, 15 with the default width
	localparam logic [PRG_BANK_W-1:0] LAST_BANK = '1;

	mapper_e               family;     // Decoded board family
	logic                  reg_wr;     // Qualified write into cart space
	logic [PRG_BANK_W-1:0] prg_bank;   // Switchable bank
	logic [1:0]            outer_bank; // 232 outer 64K block
	logic [PAGE_W-1:0]     page;       // Selected 16K page

	assign family = decode_mapper(flags[MAPPER_W-1:0]);
	assign reg_wr = ce && prg_write && prg_ain[15]; // Only $8000-$FFFF

	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			prg_bank   <= '0;
			outer_bank <= '0;
		end else if (reg_wr) begin
			case (family)
				GXROM: begin
					prg_bank <= PRG_BANK_W'(prg_din[5:4]); // 32K bank
				end
				CAMERICA: begin
					if (prg_ain[14]) begin // $C000 and up
						prg_bank <= PRG_BANK_W'(prg_din[3:0]);
					end
				end
				CAMERICA_232: begin
					if (prg_ain[14]) begin
						prg_bank[1:0] <= prg_din[1:0]; // Inner bank only
					end else begin
						outer_bank <= prg_din[4:3]; // $8000-$BFFF outer select
					end
				end
				BANDAI_70: begin
					prg_bank <= PRG_BANK_W'(prg_din[7:4]);
				end
				BANDAI_152: begin
					prg_bank <= PRG_BANK_W'(prg_din[6:4]);
				end
				HOLY_DIVER: begin
					prg_bank <= PRG_BANK_W'(prg_din[2:0]);
				end
				default: begin
					prg_bank <= prg_bank; // NROM has no registers
				end
			endcase
		end
	end

	// Page select, combinational from address and registers
	always_comb begin
		case (family)
			NROM: begin
				page = PAGE_W'(prg_ain[14]); // Flat 32K
			end
			GXROM: begin
				page = PAGE_W'({prg_bank, prg_ain[14]}); // 32K bank, A14 passes
			end
			CAMERICA_232: begin
				if (prg_ain[14])
					page = PAGE_W'({outer_bank, 2'b11}); // Last bank of outer block
				else
					page = PAGE_W'({outer_bank, prg_bank[1:0]});
			end
			default: begin
				// 16K switchable low window, fixed upper window
				if (prg_ain[14])
					page = PAGE_W'(LAST_BANK);
				else
					page = PAGE_W'(prg_bank);
			end
		endcase
	end

	assign prg_map = {page, prg_ain[13:0]};

endmodule

/* src/chr_bank_unit.sv */
// CHR bank, mirroring and nametable select

`timescale 1ns/1ns

module chr_bank_unit import mapper_pkg::*; #(
	parameter int CHR_BANK_W = 4 // CHR bank register width
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,        // M2 strobe
	input  logic                   enable,    // Mapper enabled
	input  logic [FLAGS_W-1:0]     flags,     // Cart flags
	input  logic [CPU_ADDR_W-1:0]  prg_ain,   // CPU address
	input  logic                   prg_write, // CPU write level
	input  logic [DATA_W-1:0]      prg_din,   // CPU write data
	input  logic [PPU_ADDR_W-1:0]  chr_ain,   // PPU address
	output logic [CART_ADDR_W-1:0] chr_map,   // Mapped CHR address
	output logic                   nt_a10     // Nametable A10
);

	// Room for the 8K bank between region prefix and 13 bit offset
	localparam int BANK_FIELD_W = CART_ADDR_W - 2 - 13;

	mapper_e               family;
	logic                  reg_wr;     // Qualified write into cart space
	logic                  holy_fam;   // 78, 70 or 152
	logic                  one_screen; // Mirroring bit picks a single screen
	logic [1:0]            submapper;
	logic [CHR_BANK_W-1:0] chr_bank;   // 8K CHR bank
	logic                  mirroring;  // Holy Diver/Bandai mirror control
	logic                  screen_sel; // Fire Hawk screen select

	assign family    = decode_mapper(flags[MAPPER_W-1:0]);
	assign reg_wr    = ce && prg_write && prg_ain[15];
	assign submapper = flags[FLAG_SUBMAPPER_LO+1:FLAG_SUBMAPPER_LO];
	assign holy_fam  = (family == HOLY_DIVER) || (family == BANDAI_70) ||
		(family == BANDAI_152);
	assign one_screen = (submapper == 2'd1) || (family == BANDAI_152);

	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			chr_bank   <= '0;
			mirroring  <= flags[FLAG_MIRROR_VERT]; // Start from header mirroring
			screen_sel <= 1'b0;
		end else if (reg_wr) begin
			case (family)
				GXROM: begin
					chr_bank <= CHR_BANK_W'(prg_din[1:0]);
				end
				BANDAI_70: begin
					chr_bank <= CHR_BANK_W'(prg_din[3:0]);
				end
				BANDAI_152: begin
					chr_bank  <= CHR_BANK_W'(prg_din[3:0]);
					mirroring <= prg_din[7]; // Screen in bit 7
				end
				HOLY_DIVER: begin
					chr_bank  <= CHR_BANK_W'(prg_din[7:4]);
					mirroring <= prg_din[3];
				end
				CAMERICA, CAMERICA_232: begin
					if (prg_ain[14:13] == 2'b00) begin // $8000-$9FFF only
						screen_sel <= prg_din[4];
					end
				end
				default: begin
					chr_bank <= chr_bank; // NROM, nothing to latch
				end
			endcase
		end
	end

	// Nametable A10 per family
	always_comb begin
		if (holy_fam) begin
			if (one_screen)
				nt_a10 = mirroring; // Lower or upper screen
			else
				nt_a10 = mirroring ? chr_ain[10] : chr_ain[11];
		end else if ((family == CAMERICA) || (family == CAMERICA_232)) begin
			// Fire Hawk runs with horizontal header and picks the screen itself
			nt_a10 = flags[FLAG_MIRROR_VERT] ? chr_ain[10] : screen_sel;
		end else begin
			nt_a10 = flags[FLAG_MIRROR_VERT] ? chr_ain[10] : chr_ain[11];
		end
	end

	assign chr_map = {CHR_REGION, BANK_FIELD_W'(chr_bank), chr_ain[12:0]};

endmodule

/* src/cart_bus_select.sv */
// Cart bus outputs and access permissions

`timescale 1ns/1ns

module cart_bus_select import mapper_pkg::*; (
	input  logic                   enable,    // Mapper enabled
	input  logic [FLAGS_W-1:0]     flags,     // Cart flags
	input  logic [CPU_ADDR_W-1:0]  prg_ain,   // CPU address
	input  logic                   prg_write, // CPU write level
	input  logic [PPU_ADDR_W-1:0]  chr_ain,   // PPU address
	input  logic [CART_ADDR_W-1:0] prg_map,   // From PRG unit
	input  logic [CART_ADDR_W-1:0] chr_map,   // From CHR unit
	input  logic                   nt_a10,    // From CHR unit
	output logic [CART_ADDR_W-1:0] prg_aout,
	output logic                   prg_allow, // PRG access granted
	output logic [CART_ADDR_W-1:0] chr_aout,
	output logic                   chr_allow, // CHR write granted
	output logic                   vram_a10,  // CIRAM A10
	output logic                   vram_ce    // Route to internal 2K VRAM
);

	logic prg_rom_rd; // ROM read cycle in $8000-$FFFF
	logic chr_ram_wr; // Header says CHR RAM
	logic nt_access;  // PPU in $2000-$3FFF

	assign prg_rom_rd = prg_ain[15] && !prg_write; // ROM never takes writes
	assign chr_ram_wr = flags[FLAG_CHR_RAM];
	assign nt_access  = chr_ain[13];

	// Everything parks at inactive values while disabled
	assign prg_aout  = enable ? prg_map : '0;
	assign chr_aout  = enable ? chr_map : '0;
	assign prg_allow = enable && prg_rom_rd;
	assign chr_allow = enable && chr_ram_wr;
	assign vram_a10  = enable && nt_a10;
	assign vram_ce   = enable && nt_access;

endmodule

/* src/discrete_mapper.sv */
// Discrete NES mapper core
// NROM, GxROM, Camerica and Holy Diver/Bandai boards

`timescale 1ns/1ns

module discrete_mapper import mapper_pkg::*; #(
	parameter int PRG_BANK_W = 4, // Widen for oversize PRG
	parameter int CHR_BANK_W = 4  // Widen for oversize CHR
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,        // M2 strobe
	input  logic                   enable,    // Mapper enabled
	input  logic [FLAGS_W-1:0]     flags,     // Cart flags
	input  logic [CPU_ADDR_W-1:0]  prg_ain,   // CPU address
	input  logic                   prg_read,  // CPU read strobe
	input  logic                   prg_write, // CPU write level
	input  logic [DATA_W-1:0]      prg_din,   // CPU write data
	input  logic [PPU_ADDR_W-1:0]  chr_ain,   // PPU address
	output logic [CART_ADDR_W-1:0] prg_aout,  // PRG address into cart memory
	output logic                   prg_allow,
	output logic [CART_ADDR_W-1:0] chr_aout,  // CHR address into cart memory
	output logic                   chr_allow,
	output logic                   vram_a10,
	output logic                   vram_ce
);

	logic [CART_ADDR_W-1:0] prg_map; // Mapped PRG, ungated
	logic [CART_ADDR_W-1:0] chr_map; // Mapped CHR, ungated
	logic                   nt_a10;

	prg_bank_unit #(
		.PRG_BANK_W(PRG_BANK_W)
	) prg_bank_unit_i (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.enable    (enable),
		.flags     (flags),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.prg_map   (prg_map)
	);

	chr_bank_unit #(
		.CHR_BANK_W(CHR_BANK_W)
	) chr_bank_unit_i (
		.clk       (clk),
		.rst       (rst),
		.ce        (ce),
		.enable    (enable),
		.flags     (flags),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.chr_ain   (chr_ain),
		.chr_map   (chr_map),
		.nt_a10    (nt_a10)
	);

	cart_bus_select cart_bus_select_i (
		.enable    (enable),
		.flags     (flags),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.chr_ain   (chr_ain),
		.prg_map   (prg_map),
		.chr_map   (chr_map),
		.nt_a10    (nt_a10),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.chr_allow (chr_allow),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce)
	);

endmodule

/* testbench/mapper_checker.sv */
// Mapper reference model and output checker

`timescale 1ns/1ns

module mapper_checker import mapper_pkg::*; #(
	parameter int PRG_BANK_W = 4, // Must match the DUT
	parameter int CHR_BANK_W = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,
	input  logic                   enable,
	input  logic [FLAGS_W-1:0]     flags,
	input  logic [CPU_ADDR_W-1:0]  prg_ain,
	input  logic                   prg_write,
	input  logic [DATA_W-1:0]      prg_din,
	input  logic [PPU_ADDR_W-1:0]  chr_ain,
	input  logic [CART_ADDR_W-1:0] prg_aout,  // DUT outputs from here
	input  logic                   prg_allow,
	input  logic [CART_ADDR_W-1:0] chr_aout,
	input  logic                   chr_allow,
	input  logic                   vram_a10,
	input  logic                   vram_ce,
	output int                     check_count, // Compared cycles
	output int                     error_count  // Mismatching signals
);

	localparam int PAGE_W      = CART_ADDR_W - 14; // 16K page number
	localparam int CHR_FIELD_W = CART_ADDR_W - 15; // Bank field between prefix and offset
	localparam int FIXED_BANK  = 15; // Upper 16K window of the 16K boards

	logic [PRG_BANK_W-1:0]  m_prg;       // Model PRG bank
	logic [1:0]             m_outer;     // Model 232 outer block
	logic [CHR_BANK_W-1:0]  m_chr;       // Model CHR bank
	logic                   m_mirror;    // Model Holy Diver mirroring
	logic                   m_screen;    // Model Fire Hawk screen
	logic                   model_valid; // Set once registers are known
	logic [7:0]             mnum;
	logic                   holy;
	logic                   cam;
	logic [CART_ADDR_W-1:0] exp_prg;
	logic [CART_ADDR_W-1:0] exp_chr;

	assign mnum = flags[7:0];
	assign holy = (mnum == 8'd78) || (mnum == 8'd70) || (mnum == 8'd152);
	assign cam  = (mnum == 8'd71) || (mnum == 8'd232);

	initial begin
		check_count = 0;
		error_count = 0;
		model_valid = 1'b0;
	end

	task automatic compare_value(input string name, input logic [CART_ADDR_W-1:0] exp,
		input logic [CART_ADDR_W-1:0] act);
		if (exp !== act) begin
			error_count++;
			$display("CHECK FAILED %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	// Register model on the rising edge
	always @(posedge clk) begin
		if (rst || !enable) begin
			m_prg       <= '0;
			m_outer     <= '0;
			m_chr       <= '0;
			m_mirror    <= flags[FLAG_MIRROR_VERT]; // Header mirroring as start
			m_screen    <= 1'b0;
			model_valid <= 1'b1;
		end else if (ce && prg_write && prg_ain[15]) begin
			case (mnum)
				8'd66: begin
					m_prg <= PRG_BANK_W'(prg_din[5:4]);
					m_chr <= CHR_BANK_W'(prg_din[1:0]);
				end
				8'd71: begin
					if (prg_ain[14])
						m_prg <= PRG_BANK_W'(prg_din[3:0]);
					if (prg_ain[14:13] == 2'b00)
						m_screen <= prg_din[4]; // $8000-$9FFF
				end
				8'd232: begin
					if (prg_ain[14])
						m_prg[1:0] <= prg_din[1:0];
					else
						m_outer <= prg_din[4:3];
					if (prg_ain[14:13] == 2'b00)
						m_screen <= prg_din[4];
				end
				8'd70: begin
					m_prg <= PRG_BANK_W'(prg_din[7:4]);
					m_chr <= CHR_BANK_W'(prg_din[3:0]);
				end
				8'd152: begin
					m_prg    <= PRG_BANK_W'(prg_din[6:4]);
					m_chr    <= CHR_BANK_W'(prg_din[3:0]);
					m_mirror <= prg_din[7];
				end
				8'd78: begin
					m_prg    <= PRG_BANK_W'(prg_din[2:0]);
					m_chr    <= CHR_BANK_W'(prg_din[7:4]);
					m_mirror <= prg_din[3];
				end
				default: ; // NROM and unknown numbers keep nothing
			endcase
		end
	end

	function automatic logic [PAGE_W-1:0] exp_page();
		if (mnum == 8'd66)
			return PAGE_W'({m_prg, prg_ain[14]});
		if (mnum == 8'd232)
			return prg_ain[14] ? PAGE_W'({m_outer, 2'b11}) : PAGE_W'({m_outer, m_prg[1:0]});
		if (cam || holy)
			return prg_ain[14] ? PAGE_W'(FIXED_BANK) : PAGE_W'(m_prg);
		return PAGE_W'(prg_ain[14]); // Flat 32K
	endfunction

	function automatic logic exp_nt();
		if (holy) begin
			if ((flags[FLAG_SUBMAPPER_LO +: 2] == 2'd1) || (mnum == 8'd152))
				return m_mirror; // One-screen
			return m_mirror ? chr_ain[10] : chr_ain[11];
		end
		if (flags[FLAG_MIRROR_VERT])
			return chr_ain[10];
		return cam ? m_screen : chr_ain[11];
	endfunction

	// Outputs settled half a cycle after the drive point
	always @(negedge clk) begin
		if (model_valid) begin
			exp_prg = enable ? {exp_page(), prg_ain[13:0]} : '0;
			exp_chr = enable ? {CHR_REGION, CHR_FIELD_W'(m_chr), chr_ain[12:0]} : '0;
			check_count++;
			compare_value("prg_aout", exp_prg, prg_aout);
			compare_value("chr_aout", exp_chr, chr_aout);
			compare_value("prg_allow", enable && prg_ain[15] && !prg_write, prg_allow);
			compare_value("chr_allow", enable && flags[FLAG_CHR_RAM], chr_allow);
			compare_value("vram_a10", enable && exp_nt(), vram_a10);
			compare_value("vram_ce", enable && chr_ain[13], vram_ce);
		end
	end

endmodule

/* testbench/tb_discrete_mapper.sv */
// Discrete mapper testbench
// Seeded random CPU and PPU traffic over every board family

`timescale 1ns/1ns

module tb_discrete_mapper import mapper_pkg::*; ();

	logic                   clk;
	logic                   rst;
	logic                   ce;
	logic                   enable;
	logic [FLAGS_W-1:0]     flags;
	logic [CPU_ADDR_W-1:0]  prg_ain;
	logic                   prg_read;
	logic                   prg_write;
	logic [DATA_W-1:0]      prg_din;
	logic [PPU_ADDR_W-1:0]  chr_ain;
	logic [CART_ADDR_W-1:0] prg_aout;
	logic                   prg_allow;
	logic [CART_ADDR_W-1:0] chr_aout;
	logic                   chr_allow;
	logic                   vram_a10;
	logic                   vram_ce;
	int                     check_count; // From checker
	int                     error_count; // From checker
	int                     timeouts;
	integer                 seed;
	logic [7:0]             mapper_list [8]; // Mapper 4 is unsupported and runs as NROM

	always #5 clk = ~clk;

	discrete_mapper #(.PRG_BANK_W(4), .CHR_BANK_W(4)) discrete_mapper_i (
		.clk(clk), .rst(rst), .ce(ce), .enable(enable), .flags(flags),
		.prg_ain(prg_ain), .prg_read(prg_read), .prg_write(prg_write),
		.prg_din(prg_din), .chr_ain(chr_ain), .prg_aout(prg_aout),
		.prg_allow(prg_allow), .chr_aout(chr_aout), .chr_allow(chr_allow),
		.vram_a10(vram_a10), .vram_ce(vram_ce)
	);

	mapper_checker #(.PRG_BANK_W(4), .CHR_BANK_W(4)) checker_i (
		.clk(clk), .rst(rst), .ce(ce), .enable(enable), .flags(flags),
		.prg_ain(prg_ain), .prg_write(prg_write), .prg_din(prg_din),
		.chr_ain(chr_ain), .prg_aout(prg_aout), .prg_allow(prg_allow),
		.chr_aout(chr_aout), .chr_allow(chr_allow), .vram_a10(vram_a10),
		.vram_ce(vram_ce), .check_count(check_count), .error_count(error_count)
	);

	// Wait until the checker has compared up to target cycles
	task automatic wait_checks(input int target, input int limit);
		int n;
		n = 0;
		while ((check_count < target) && (n < limit)) begin
			@(posedge clk);
			n++;
		end
		if (check_count < target) begin
			$display("Timeout: checker stalled before reaching %0d compared cycles", target);
			timeouts++;
		end
	endtask

	task automatic drive_random();
		logic [31:0] r;
		logic [31:0] d;
		r         = $random(seed);
		d         = $random(seed);
		ce        = (r[2:0] != 3'd0); // Mostly strobed
		prg_write = r[3];
		prg_read  = !r[3];
		enable    = (r[9:4] != 6'd0); // Rare drop clears the banks
		prg_ain   = r[31:16];
		prg_din   = d[DATA_W-1:0];
		chr_ain   = d[DATA_W +: PPU_ADDR_W];
	endtask

	// New board setup while disabled, then random traffic
	task automatic run_phase(input logic [7:0] mnum, input logic vert, input logic sub,
		input int cycles);
		int target;
		@(posedge clk);
		#1;
		enable                     = 1'b0;
		flags                      = $random(seed);
		flags[7:0]                 = mnum;
		flags[FLAG_MIRROR_VERT]    = vert;
		flags[FLAG_SUBMAPPER_LO +: 2] = sub ? 2'b01 : 2'b10;
		target = check_count + 2;
		wait_checks(target, 10);
		#1;
		enable = 1'b1;
		repeat (cycles) begin
			@(posedge clk);
			#1;
			drive_random();
		end
	endtask

	initial begin
		int m;
		int cfg;
		int target;
		seed      = 32'h0c819d7a;
		clk       = 1'b0;
		rst       = 1'b1;
		ce        = 1'b0;
		enable    = 1'b1;
		flags     = '0;
		prg_ain   = '0;
		prg_read  = 1'b0;
		prg_write = 1'b0;
		prg_din   = '0;
		chr_ain   = '0;
		timeouts  = 0;
		mapper_list = '{8'd0, 8'd66, 8'd71, 8'd232, 8'd78, 8'd70, 8'd152, 8'd4};
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		for (m = 0; m < 8; m++) begin
			for (cfg = 0; cfg < 4; cfg++) begin
				run_phase(mapper_list[m], cfg[0], cfg[1], 150); // Mirroring x submapper
			end
		end
		target = check_count + 3; // Let the last cycles drain through the checker
		wait_checks(target, 20);
		$display("Compared %0d cycles, %0d mismatches, %0d timeouts",
			check_count, error_count, timeouts);
		if ((error_count == 0) && (timeouts == 0) && (check_count > 0)) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* sources.f */
src/mapper_pkg.sv
src/prg_bank_unit.sv
src/chr_bank_unit.sv
src/cart_bus_select.sv
src/discrete_mapper.sv
testbench/mapper_checker.sv
testbench/tb_discrete_mapper.sv

/* Bender.yml */
package:
  name: discrete_mapper

sources:
  - src/mapper_pkg.sv
  - src/prg_bank_unit.sv
  - src/chr_bank_unit.sv
  - src/cart_bus_select.sv
  - src/discrete_mapper.sv
  - target: test
    files:
      - testbench/mapper_checker.sv
      - testbench/tb_discrete_mapper.sv
